/* filelist.f */
+incdir+rtl
rtl/stream_pkg.sv
rtl/beat_framer.sv
rtl/valid_delay.sv
rtl/packet_summer.sv
rtl/stream_sum_top.sv
tests/stream_sum_tb.sv

/* rtl/beat_framer.sv */
// Beat framer; in_last is only looked at with in_valid, and packets over STREAM_MAX_BEATS are split
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module beat_framer
  import stream_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   in_valid,
  input  data_t  in_data,
  input  logic   in_last,
  output logic   beat_valid,
  output beat_t  beat
);

  // ----------------------------------------
  // Beat numbering
  // ----------------------------------------

  // Index that the next accepted beat will carry
  index_t beat_index;

  // The beat at the cap closes the packet even if the source has not flagged it
  logic   at_cap;

  // High when the current input beat ends a packet, by flag or by length
  logic   close_packet;

  assign at_cap       = (beat_index == index_t'(`STREAM_MAX_BEATS - 1));
  assign close_packet = in_last || at_cap;

  // The counter returns to 0 after every closing beat, so the remainder of
  // a split packet starts again from the first position
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_index <= '0;
    end else if (in_valid) begin
      if (close_packet) begin
        beat_index <= '0;
      end else begin
        beat_index <= beat_index + index_t'(1);
      end
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------

  // The strobe follows the input by exactly one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= in_valid;
    end
  end

  // The beat is only captured on a valid input, so it holds its last value
  // through idle cycles and is meaningful only while beat_valid is high
  always_ff @(posedge clk) begin
    if (in_valid) begin
      beat.data  <= in_data;
      beat.index <= beat_index;
      beat.last  <= close_packet;
    end
  end

endmodule

`default_nettype wire

/* rtl/packet_summer.sv */
// Packet summer; trusts the incoming index to mark packet starts and gives no flow control
`timescale 1ns/1ps
`default_nettype none

module packet_summer
  import stream_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    dly_valid,
  input  beat_t   dly_beat,
  output logic    result_valid,
  output result_t result
);

  // ----------------------------------------
  // Accumulation
  // ----------------------------------------

  // Running sum of the beats seen so far in the current packet
  sum_t acc;

  // Value the current beat is added to
  sum_t base_sum;

  // Sum including the current beat
  sum_t next_sum;

  // A beat at index 0 starts a fresh packet whatever the accumulator holds,
  // which also recovers cleanly from a packet that was cut short
  always_comb begin
    if (dly_beat.index == '0) begin
      base_sum = '0;
    end else begin
      base_sum = acc;
    end
    next_sum = base_sum + sum_t'(dly_beat.data);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (dly_valid) begin
      acc <= next_sum;
    end
  end

  // ----------------------------------------
  // Result output
  // ----------------------------------------

  // One pulse per packet, one cycle after its last beat arrives
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= dly_valid && dly_beat.last;
    end
  end

  // The result holds until the next packet closes
  // The count is the last beat's index plus one, so a full packet reads 16
  always_ff @(posedge clk) begin
    if (dly_valid && dly_beat.last) begin
      result.sum   <= next_sum;
      result.count <= count_t'(dly_beat.index) + count_t'(1);
    end
  end

endmodule

`default_nettype wire

/* rtl/stream_params.svh */
// Widths and depths shared by the packet summing stream; sum width must cover MAX_BEATS full beats
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Width of one input data word
`define STREAM_DATA_WIDTH 16

// Longest packet the framer passes on before it forces a cut
`define STREAM_MAX_BEATS 16

// Bits needed to number a beat from 0 to STREAM_MAX_BEATS - 1
`define STREAM_INDEX_WIDTH 4

// Register stages between the framer and the summer
`define STREAM_DELAY_STAGES 3

`endif

/* rtl/stream_pkg.sv */
// Types for the packet summing stream; all widths follow the macros in stream_params.svh
`default_nettype none

`include "stream_params.svh"

package stream_pkg;

  // ----------------------------------------
  // Width typedefs
  // ----------------------------------------

  // One beat's data word
  typedef logic [`STREAM_DATA_WIDTH-1:0] data_t;

  // Position of a beat within its packet, counting from 0
  typedef logic [`STREAM_INDEX_WIDTH-1:0] index_t;

  // Number of beats in a packet, one bit wider than the index so it can hold the cap
  typedef logic [`STREAM_INDEX_WIDTH:0] count_t;

  // Packet sum, wide enough for a full-length packet of full-scale words
  typedef logic [`STREAM_DATA_WIDTH+`STREAM_INDEX_WIDTH-1:0] sum_t;

  // ----------------------------------------
  // Link structs
  // ----------------------------------------

  // A framed beat as it travels from the framer to the summer
  typedef struct packed {
    data_t  data;
    index_t index;
    logic   last;
  } beat_t;

  // The per-packet result
  typedef struct packed {
    sum_t   sum;
    count_t count;
  } result_t;

endpackage

`default_nettype wire

/* rtl/stream_sum_top.sv */
// Packet summing top level; results appear STREAM_DELAY_STAGES + 2 cycles after each last beat
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module stream_sum_top
  import stream_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  data_t   in_data,
  input  logic    in_last,
  output logic    result_valid,
  output result_t result
);

  // Width of a beat once flattened for the delay line
  localparam int BEAT_BITS = $bits(beat_t);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------

  // Framer to delay line
  logic  beat_valid;
  beat_t beat;

  // Delay line to summer, first as a flat vector and then as a struct again
  logic                 dly_valid;
  logic [BEAT_BITS-1:0] dly_beat_bits;
  beat_t                dly_beat;

  assign dly_beat = beat_t'(dly_beat_bits);

  // ----------------------------------------
  // Pipeline
  // ----------------------------------------

  beat_framer i_framer (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (in_last),
    .beat_valid(beat_valid),
    .beat      (beat)
  );

  // The delay line only sees a vector, so the beat is flattened on the way in
  valid_delay #(
    .NUM_STAGES(`STREAM_DELAY_STAGES),
    .BIT_WIDTH (BEAT_BITS)
  ) i_delay (
    .clk      (clk),
    .rst      (rst),
    .in_valid (beat_valid),
    .in       (beat),
    .out_valid(dly_valid),
    .out      (dly_beat_bits)
  );

  packet_summer i_summer (
    .clk         (clk),
    .rst         (rst),
    .dly_valid   (dly_valid),
    .dly_beat    (dly_beat),
    .result_valid(result_valid),
    .result      (result)
  );

endmodule

`default_nettype wire

/* rtl/valid_delay.sv */
// Fixed delay line for a valid strobe and its payload; NUM_STAGES of 0 gives a combinational path
`timescale 1ns/1ps
`default_nettype none

module valid_delay #(
  // Number of register stages, 0 or more
  parameter int NUM_STAGES = 0,
  // Payload width, 1 or more
  parameter int BIT_WIDTH  = 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  logic [BIT_WIDTH-1:0] in,
  output logic                 out_valid,
  output logic [BIT_WIDTH-1:0] out
);

  // ----------------------------------------
  // Stage storage
  // ----------------------------------------

  // Entry 0 is the input itself and entry NUM_STAGES is the output
  logic [NUM_STAGES:0]                stage_valid;
  logic [NUM_STAGES:0][BIT_WIDTH-1:0] stage_data;

  assign stage_valid[0] = in_valid;
  assign stage_data[0]  = in;

  // ----------------------------------------
  // Register chain
  // ----------------------------------------

  for (genvar i = 1; i <= NUM_STAGES; i++) begin : gen_stage
    // The valid bit shifts every cycle and clears on reset
    always_ff @(posedge clk) begin
      if (rst) begin
        stage_valid[i] <= 1'b0;
      end else begin
        stage_valid[i] <= stage_valid[i-1];
      end
    end

    // The payload only moves along with a valid bit, so idle cycles
    // leave the datapath registers still
    always_ff @(posedge clk) begin
      if (stage_valid[i-1]) begin
        stage_data[i] <= stage_data[i-1];
      end
    end
  end

  // With no stages these are plain wires from the input
  assign out_valid = stage_valid[NUM_STAGES];
  assign out       = stage_data[NUM_STAGES];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the packet summer testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when the testbench fails.
set -e

cd "$(dirname "$0")"

verilator \
  --binary \
  --timing \
  --assert \
  --timescale 1ns/1ps \
  --top-module stream_sum_tb \
  --Mdir obj_dir \
  -o stream_sum_sim \
  -f filelist.f

./obj_dir/stream_sum_sim

/* tests/stream_sum_tb.sv */
// Testbench for the packet summer; expects the default STREAM_DELAY_STAGES and never stalls results
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module stream_sum_tb
  import stream_pkg::*;
();

  // ----------------------------------------
  // Constants and types
  // ----------------------------------------

  localparam int RESET_CYCLES = 2;
  localparam int IDLE_CYCLES  = 8;
  localparam int DRAIN_CYCLES = 3;

  // Cycles from the cycle that carries a last beat to the cycle of its result pulse
  localparam int LATENCY = `STREAM_DELAY_STAGES + 2;

  // One row of the stimulus table
  // A row with rand_data set takes its word from $urandom when it is applied
  typedef struct packed {
    data_t      data;
    logic       last;
    logic       rand_data;
    logic [7:0] gap;
  } entry_t;

  // A result the model expects, with the cycle on which it has to show up
  typedef struct packed {
    result_t     res;
    logic [31:0] cycle;
  } expect_t;

  // ----------------------------------------
  // DUT and clock
  // ----------------------------------------

  logic    clk;
  logic    rst;
  logic    in_valid;
  data_t   in_data;
  logic    in_last;
  logic    result_valid;
  result_t result;

  stream_sum_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_last     (in_last),
    .result_valid(result_valid),
    .result      (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // Model state
  // ----------------------------------------

  entry_t      table_q[$];
  expect_t     exp_q[$];
  int unsigned cycle_count;
  int unsigned timeout_limit;

  // Framer rules as seen by the model: position in the packet and running sum
  int          model_index;
  sum_t        model_sum;

  // Counts rising edges, so a value read between edges names the last edge
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ----------------------------------------
  // Error reporting and watchdog
  // ----------------------------------------

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  // Guarded until the limit is known, which happens before the first edge anyway
  always @(posedge clk) begin
    if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: the run passed %0d cycles and did not finish", timeout_limit);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // Monitor
  // ----------------------------------------

  // Sampled on the falling edge, half a cycle away from every DUT update
  always @(negedge clk) begin
    if (!rst) begin
      if (exp_q.size() != 0 && exp_q[0].cycle == cycle_count) begin
        assert (result_valid === 1'b1)
          else report_mismatch($sformatf("result_valid low at cycle %0d, a result was due",
                                         cycle_count));
        assert (result === exp_q[0].res)
          else report_mismatch($sformatf("result sum %0h count %0d, expected sum %0h count %0d",
                                         result.sum, result.count,
                                         exp_q[0].res.sum, exp_q[0].res.count));
        void'(exp_q.pop_front());
      end else begin
        assert (result_valid === 1'b0)
          else report_mismatch($sformatf("result_valid high at cycle %0d, no result was due",
                                         cycle_count));
      end
    end
  end

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------

  function automatic void add_entry(input data_t data, input logic last,
                                    input logic rand_data, input logic [7:0] gap);
    entry_t e;
    e.data      = data;
    e.last      = last;
    e.rand_data = rand_data;
    e.gap       = gap;
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    int i;
    // Single beat packet
    add_entry(16'h1234, 1'b1, 1'b0, 8'd8);
    // Three beats with idle cycles between them
    add_entry(16'h0010, 1'b0, 1'b0, 8'd2);
    add_entry(16'h0020, 1'b0, 1'b0, 8'd1);
    add_entry(16'h0030, 1'b1, 1'b0, 8'd8);
    // Back to back packets, several results in flight at once
    add_entry(16'h0100, 1'b0, 1'b0, 8'd0);
    add_entry(16'h0200, 1'b1, 1'b0, 8'd0);
    add_entry(16'h0300, 1'b1, 1'b0, 8'd0);
    add_entry(16'h0400, 1'b0, 1'b0, 8'd0);
    add_entry(16'h0500, 1'b1, 1'b0, 8'd8);
    // A 20 beat packet that the framer cuts into 16 and 4
    for (i = 0; i < 20; i++) begin
      add_entry(data_t'(i * 17 + 4096), (i == 19), 1'b0, (i == 19) ? 8'd8 : 8'd0);
    end
    // Full scale words, the largest sum a packet can reach
    for (i = 0; i < 16; i++) begin
      add_entry(16'hffff, (i == 15), 1'b0, (i == 15) ? 8'd4 : 8'd0);
    end
    // Random words in the upper half of the range
    for (i = 0; i < 16; i++) begin
      add_entry('0, (i == 15), 1'b1, (i == 15) ? 8'd3 : 8'd0);
    end
    for (i = 0; i < 5; i++) begin
      add_entry('0, (i == 4), 1'b1, (i == 4) ? 8'd8 : 8'd1);
    end
  endfunction

  // Drives one row for a single cycle, updates the model, then idles for the gap
  task automatic apply_entry(input entry_t e);
    data_t   d;
    logic    closes;
    expect_t ex;
    if (e.rand_data) begin
      d = data_t'($urandom) | 16'h8000;
    end else begin
      d = e.data;
    end
    in_valid = 1'b1;
    in_data  = d;
    in_last  = e.last;

    // A packet closes on its flag or on the 16th beat
    closes = e.last || (model_index == `STREAM_MAX_BEATS - 1);
    if (model_index == 0) begin
      model_sum = '0;
    end
    model_sum = model_sum + sum_t'(d);
    if (closes) begin
      ex.res.sum   = model_sum;
      ex.res.count = count_t'(model_index + 1);
      // The result pulse comes LATENCY cycles after the cycle that carries the beat
      ex.cycle     = cycle_count + LATENCY;
      exp_q.push_back(ex);
      model_index  = 0;
    end else begin
      model_index  = model_index + 1;
    end

    @(posedge clk);
    #1;
    // Idle cycles carry junk data and a raised last flag that the DUT must ignore
    in_valid = 1'b0;
    in_data  = ~d;
    in_last  = 1'b1;
    repeat (e.gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    int unsigned gap_total;
    int          n;
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_data     = '0;
    in_last     = 1'b0;
    model_index = 0;
    model_sum   = '0;
    void'($urandom(39));

    build_table();
    gap_total = 0;
    foreach (table_q[k]) begin
      gap_total = gap_total + 32'(table_q[k].gap);
    end
    timeout_limit = table_q.size() + gap_total + `STREAM_DELAY_STAGES + 20
                    + RESET_CYCLES + IDLE_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet period, the monitor checks that no result appears
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      #1;
    end

    for (n = 0; n < table_q.size(); n++) begin
      apply_entry(table_q[n]);
    end

    // Let the monitor consume the remaining results, then watch a few more cycles
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (DRAIN_CYCLES) begin
      @(posedge clk);
      #1;
    end

    if (exp_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Results were still expected when the run ended");
      $display("test failed");
      $fatal(1, "missing results");
    end
  end

endmodule

`default_nettype wire
